//--- cft_pkg.sv
package cft_pkg;

   //////////////////////////////
   // Field widths
   //////////////////////////////

   localparam int WORD_W   = 16;               // Machine word
   localparam int OP_W     = 4;                // Opcode field
   localparam int OFFSET_W = 10;               // Page offset in IR
   localparam int PAGE_W   = 6;                // PC page bits, PC[15:10]

   typedef logic [WORD_W-1:0] word_t;          // ibus, addresses, IR

   //////////////////////////////
   // ALU flags
   //////////////////////////////

   // Bit order matches the skip mask, v at bit 3 down to z at bit 0
   typedef struct packed {
      logic v;                                 // Overflow
      logic l;                                 // Link
      logic n;                                 // Negative
      logic z;                                 // Zero
   } flags_t;

   //////////////////////////////
   // Instruction register view
   //////////////////////////////

   typedef struct packed {
      logic [OP_W-1:0]     op;                 // IR[15:12]
      logic                ind;                // IR[11], indirect
      logic                cur_page;           // IR[10], current page
      logic [OFFSET_W-1:0] offset;             // IR[9:0]
   } ir_fields_t;

   // Same offset bits, read as a skip condition
   typedef struct packed {
      logic [OFFSET_W-6:0] rsvd;               // IR[9:5], not part of the test
      logic                invert;             // IR[4]
      flags_t              mask;               // IR[3:0]
   } skip_cond_t;

   //////////////////////////////
   // Block results
   //////////////////////////////

   typedef struct packed {
      logic  valid;                            // One cycle after RAGL
      word_t addr;                             // Operand address
   } agl_result_t;

   // Control bus as seen by the rest of the machine
   typedef struct packed {
      logic            ir0;                    // IR[0]
      logic            ir2;                    // IR[2]
      logic            ir11;                   // IR[11], indirection
      logic [OP_W-1:0] ir12_15;                // IR[15:12]
      logic            skip;                   // Skip request, active high
      logic            ibus_en;                // We are driving ibus
      word_t           ibus;                   // Zero when not driving
   } cbus_t;

endpackage

//--- ir_decode.sv
module ir_decode import cft_pkg::*; (
   input  logic       clk,                     // Board clock
   input  logic       rst_n,                   // Sync reset, active low
   input  word_t      ibus_in,                 // Internal bus word
   input  logic       wir,                     // Write IR strobe
   output ir_fields_t fields                   // IR split into fields
);

   word_t ir_q;                                // The instruction register

   //////////////////////////////
   // Register
   //////////////////////////////

   // Loaded on WIR, new fields visible from the next cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ir_q <= '0;                           // IR reads as zero after reset
      end else if (wir) begin
         ir_q <= ibus_in;                      // Latch the fetched word
      end
   end

   //////////////////////////////
   // Field view
   //////////////////////////////

   // Downstream blocks only see named fields
   always_comb begin
      fields = ir_fields_t'(ir_q);             // Op, ind, cur_page, offset
   end

endmodule

//--- skip_branch_logic.sv
module skip_branch_logic import cft_pkg::*; (
   input  logic       clk,                     // Board clock
   input  logic       rst_n,                   // Sync reset, active low
   input  ir_fields_t fields,                  // Current IR fields
   input  flags_t     flags,                   // ALU flags
   input  logic       skip_test,               // Evaluate the condition
   input  logic       skip_ext,                // External skip level
   output logic       skip_taken               // One-cycle skip pulse
);

   skip_cond_t   cond;                         // Offset read as a condition
   logic [3:0]   sel_flags;                    // Flags picked by the mask
   logic         flag_hit;                     // Any selected flag set
   logic         skip_now;                     // Outcome of this cycle
   logic         skip_q;                       // Registered outcome

   //////////////////////////////
   // Condition test
   //////////////////////////////

   always_comb begin
      cond      = skip_cond_t'(fields.offset); // IR[4] invert, IR[3:0] mask
      sel_flags = cond.mask & flags;           // Bitwise over v,l,n,z
      flag_hit  = |sel_flags;                  // OR of the selected flags
      // Zero mask gives hit 0, so invert alone means skip always
      skip_now  = (flag_hit ^ cond.invert) | skip_ext;
   end

   //////////////////////////////
   // Skip register
   //////////////////////////////

   // High only in the cycle after a strobe; back-to-back strobes chain
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         skip_q <= 1'b0;                       // No skip pending
      end else begin
         skip_q <= skip_test & skip_now;       // Drops without a new strobe
      end
   end

   assign skip_taken = skip_q;                 // To bus merge

endmodule

//--- addr_gen.sv
module addr_gen import cft_pkg::*; (
   input  logic              clk,              // Board clock
   input  logic              rst_n,            // Sync reset, active low
   input  ir_fields_t        fields,           // Current IR fields
   input  logic [PAGE_W-1:0] pc_hi,            // PC[15:10]
   input  logic              ragl,             // Read AGL strobe
   output agl_result_t       result            // Valid bit and address
);

   word_t addr_next;                           // Address formed this cycle
   word_t addr_q;                              // Held operand address
   logic  valid_q;                             // Set for one cycle per strobe

   //////////////////////////////
   // Page select
   //////////////////////////////

   always_comb begin
      if (fields.cur_page) begin
         addr_next = {pc_hi, fields.offset};   // Current page
      end else begin
         addr_next = {{PAGE_W{1'b0}}, fields.offset}; // Page zero
      end
   end

   //////////////////////////////
   // Result registers
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;                      // Bus idle after reset
      end else begin
         valid_q <= ragl;                      // Exactly one cycle per strobe
      end
   end

   // Operand address, loaded on each RAGL strobe
   always_ff @(posedge clk) begin
      if (ragl) begin
         addr_q <= addr_next;
      end
   end

   assign result = '{valid: valid_q, addr: addr_q}; // To bus merge

endmodule

//--- bus_merge.sv
module bus_merge import cft_pkg::*; #(
   parameter word_t RESET_VECTOR = 16'h8000    // Word driven during reset hold
) (
   input  ir_fields_t  fields,                 // Current IR fields
   input  logic        skip_taken,             // From skip logic
   input  agl_result_t agl,                    // From address generation
   input  logic        rsthold,                // Reset hold level
   output cbus_t       cbus                    // Control bus outputs
);

   logic  drive_en;                            // Someone owns ibus
   word_t drive_val;                           // Word put on ibus

   //////////////////////////////
   // ibus priority
   //////////////////////////////

   // Reset hold wins over the AGL, whatever it shows
   always_comb begin
      if (rsthold) begin
         drive_en  = 1'b1;
         drive_val = RESET_VECTOR;             // CPU fetches from the vector
      end else if (agl.valid) begin
         drive_en  = 1'b1;
         drive_val = agl.addr;                 // Operand address
      end else begin
         drive_en  = 1'b0;
         drive_val = '0;                       // Idle bus reads zero
      end
   end

   //////////////////////////////
   // Control bus assembly
   //////////////////////////////

   always_comb begin
      cbus         = '0;
      cbus.ir0     = fields.offset[0];         // IR[0]
      cbus.ir2     = fields.offset[2];         // IR[2]
      cbus.ir11    = fields.ind;               // IR[11]
      cbus.ir12_15 = fields.op;                // IR[15:12]
      cbus.skip    = skip_taken;               // Straight through
      cbus.ibus_en = drive_en;
      cbus.ibus    = drive_val;
   end

endmodule

//--- cft_pb1.sv
module cft_pb1 import cft_pkg::*; #(
   parameter word_t RESET_VECTOR = 16'h8000    // Passed to the bus merge
) (
   input  logic              clk,              // Board clock
   input  logic              rst_n,            // Sync reset, active low
   input  word_t             ibus_in,          // Incoming ibus word
   input  logic              wir,              // Write IR
   input  logic              ragl,             // Read AGL
   input  logic              skip_test,        // Evaluate skip condition
   input  flags_t            flags,            // ALU flags
   input  logic              skip_ext,         // External skip level
   input  logic [PAGE_W-1:0] pc_hi,            // PC[15:10]
   input  logic              rsthold,          // Reset hold level
   output cbus_t             cbus              // Control bus outputs
);

   //////////////////////////////
   // Internal wires
   //////////////////////////////

   ir_fields_t  ir_fields;                     // IR, as named fields
   logic        skip_taken;                    // Skip pulse
   agl_result_t agl_result;                    // Operand address and valid

   //////////////////////////////
   // Instruction register
   //////////////////////////////

   ir_decode ir_decode_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .ibus_in (ibus_in),
      .wir     (wir),
      .fields  (ir_fields)
   );

   //////////////////////////////
   // Skip/branch logic
   //////////////////////////////

   skip_branch_logic skip_branch_logic_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .fields     (ir_fields),
      .flags      (flags),
      .skip_test  (skip_test),
      .skip_ext   (skip_ext),
      .skip_taken (skip_taken)
   );

   //////////////////////////////
   // Address generation
   //////////////////////////////

   addr_gen addr_gen_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .fields (ir_fields),
      .pc_hi  (pc_hi),
      .ragl   (ragl),
      .result (agl_result)
   );

   //////////////////////////////
   // Bus merge
   //////////////////////////////

   // Reset vector path and AGL share ibus here
   bus_merge #(
      .RESET_VECTOR (RESET_VECTOR)
   ) bus_merge_i (
      .fields     (ir_fields),
      .skip_taken (skip_taken),
      .agl        (agl_result),
      .rsthold    (rsthold),
      .cbus       (cbus)
   );

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen (
   output logic clk,                           // Board clock, 10 ns
   output logic rst_n                          // Sync reset, active low
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int RESET_CYCLES = 4;            // Edges that see reset low

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;                   // Half period
   end

   // Released on a rising edge so the DUT sees a clean sync reset
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

//--- cft_pb1_sva.sv
module cft_pb1_sva import cft_pkg::*; #(
   parameter word_t RESET_VECTOR = 16'h8000    // Same vector as the bus merge
) (
   input logic  clk,                           // Board clock
   input logic  rst_n,                         // Sync reset, active low
   input logic  ragl,                          // Read AGL strobe
   input logic  skip_test,                     // Skip test strobe
   input logic  rsthold,                       // Reset hold level
   input cbus_t cbus                           // Control bus outputs
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_count = 0;                         // Failed assertions so far

   //////////////////////////////
   // Idle bus
   //////////////////////////////

   // No strobe last cycle and no hold, so nothing may drive
   bus_idle_without_strobe: assert property (
      @(posedge clk) disable iff (!rst_n)
      (!rsthold && !$past(ragl) && !$past(skip_test)) |-> (!cbus.ibus_en && !cbus.skip)
   ) else begin
      $error("cbus active with no strobe and no reset hold");
      fail_count++;
   end

   //////////////////////////////
   // Reset hold
   //////////////////////////////

   vector_during_hold: assert property (
      @(posedge clk) disable iff (!rst_n)
      rsthold |-> (cbus.ibus_en && (cbus.ibus == RESET_VECTOR))
   ) else begin
      $error("ibus does not carry the reset vector during reset hold");
      fail_count++;
   end

   //////////////////////////////
   // Skip pulse width
   //////////////////////////////

   // Two high cycles need two strobes in a row
   skip_one_cycle: assert property (
      @(posedge clk) disable iff (!rst_n)
      (cbus.skip && $past(cbus.skip)) |-> ($past(skip_test) && $past(skip_test, 2))
   ) else begin
      $error("skip held for two cycles without two consecutive strobes");
      fail_count++;
   end

endmodule

//--- cft_pb1_tb.sv
module cft_pb1_tb import cft_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam word_t RESET_VECTOR = 16'h8000;
   localparam int    N_IR         = 24;       // Plain IR loads
   localparam int    N_SKIP       = 200;      // Skip tests, each after a load
   localparam int    N_ADDR       = 40;       // Address reads, each after a load
   // Loads, load plus skip, load plus ragl, back-to-back ragl, hold test
   localparam int    N_STROBES    = N_IR + 2 * N_SKIP + 2 * N_ADDR + N_ADDR / 4 + 2;
   localparam int    MAX_CYCLES   = 4 * N_STROBES + 100;

   logic              clk;
   logic              rst_n;
   word_t             ibus_in;
   logic              wir;
   logic              ragl;
   logic              skip_test;
   flags_t            flags;
   logic              skip_ext;
   logic [PAGE_W-1:0] pc_hi;
   logic              rsthold;
   cbus_t             cbus;

   word_t             ir_model;                // IR after the last edge
   word_t             ir_at_edge;              // IR the last strobe saw
   flags_t            seen_flags;              // Inputs at the last edge
   logic              seen_ext;
   logic [PAGE_W-1:0] seen_pc;
   logic              seen_skip;
   logic              seen_ragl;
   cbus_t             exp_cbus;

   integer            seed;                    // $random state
   logic [31:0]       rnd;
   word_t             word;
   logic              ext;
   int                err_count   = 0;
   int                check_count = 0;
   int                err_base    = 0;
   int                chk_base    = 0;
   int                tests_done  = 0;
   int                cycles      = 0;

   tb_clock_gen clock_gen_i (.clk(clk), .rst_n(rst_n));

   cft_pb1 #(.RESET_VECTOR(RESET_VECTOR)) dut_i (
      .clk(clk), .rst_n(rst_n), .ibus_in(ibus_in), .wir(wir), .ragl(ragl),
      .skip_test(skip_test), .flags(flags), .skip_ext(skip_ext), .pc_hi(pc_hi),
      .rsthold(rsthold), .cbus(cbus)
   );

   bind cft_pb1 cft_pb1_sva #(.RESET_VECTOR(RESET_VECTOR)) sva_i (
      .clk(clk), .rst_n(rst_n), .ragl(ragl), .skip_test(skip_test),
      .rsthold(rsthold), .cbus(cbus)
   );

   //////////////////////////////
   // Reference model
   //////////////////////////////

   // ir_now gives the IR bits, ir_strobe is the IR the strobe edge saw
   function automatic cbus_t ref_cbus(input word_t ir_now, input word_t ir_strobe,
                                      input flags_t f, input logic ext_in,
                                      input logic [PAGE_W-1:0] pc, input logic did_skip,
                                      input logic did_ragl, input logic hold);
      cbus_t      r;
      logic [3:0] mask;
      logic       hit;
      word_t      addr;
      mask = ir_strobe[3:0];                   // v l n z from bit 3 down
      hit  = (mask[3] & f.v) | (mask[2] & f.l) | (mask[1] & f.n) | (mask[0] & f.z);
      addr = ir_strobe[10] ? {pc, ir_strobe[9:0]} : {6'b00_0000, ir_strobe[9:0]};
      r         = '0;
      r.ir0     = ir_now[0];
      r.ir2     = ir_now[2];
      r.ir11    = ir_now[11];
      r.ir12_15 = ir_now[15:12];
      r.skip    = did_skip & ((hit ^ ir_strobe[4]) | ext_in);
      if (hold) begin
         r.ibus_en = 1'b1;
         r.ibus    = RESET_VECTOR;             // Hold wins
      end else if (did_ragl) begin
         r.ibus_en = 1'b1;
         r.ibus    = addr;
      end
      return r;
   endfunction

   // Inputs read before this edge's stimulus lands
   always @(posedge clk) begin
      if (!rst_n) begin
         ir_model   = '0;
         ir_at_edge = '0;
         seen_flags = '0;
         seen_ext   = 1'b0;
         seen_pc    = '0;
         seen_skip  = 1'b0;
         seen_ragl  = 1'b0;
      end else begin
         ir_at_edge = ir_model;                // Strobe uses the old IR
         seen_flags = flags;
         seen_ext   = skip_ext;
         seen_pc    = pc_hi;
         seen_skip  = skip_test;
         seen_ragl  = ragl;
         if (wir) ir_model = ibus_in;
      end
   end

   //////////////////////////////
   // Compare
   //////////////////////////////

   task automatic report_mismatch(input string name, input logic [15:0] exp_v,
                                  input logic [15:0] got_v);
      err_count++;
      $display("ERROR %s at %0t: expected %h, got %h", name, $time, exp_v, got_v);
   endtask

   // Falling edge, all outputs settled
   always @(negedge clk) begin
      if (rst_n === 1'b1) begin
         exp_cbus = ref_cbus(ir_model, ir_at_edge, seen_flags, seen_ext, seen_pc,
                             seen_skip, seen_ragl, rsthold);
         check_count++;
         if (cbus.ir0 !== exp_cbus.ir0) report_mismatch("cbus.ir0", exp_cbus.ir0, cbus.ir0);
         if (cbus.ir2 !== exp_cbus.ir2) report_mismatch("cbus.ir2", exp_cbus.ir2, cbus.ir2);
         if (cbus.ir11 !== exp_cbus.ir11)
            report_mismatch("cbus.ir11", exp_cbus.ir11, cbus.ir11);
         if (cbus.ir12_15 !== exp_cbus.ir12_15)
            report_mismatch("cbus.ir12_15", exp_cbus.ir12_15, cbus.ir12_15);
         if (cbus.skip !== exp_cbus.skip)
            report_mismatch("cbus.skip", exp_cbus.skip, cbus.skip);
         if (cbus.ibus_en !== exp_cbus.ibus_en)
            report_mismatch("cbus.ibus_en", exp_cbus.ibus_en, cbus.ibus_en);
         if (cbus.ibus !== exp_cbus.ibus)
            report_mismatch("cbus.ibus", exp_cbus.ibus, cbus.ibus);
      end
   end

   //////////////////////////////
   // Stimulus helpers
   //////////////////////////////

   task automatic apply_cycle(input logic w, input logic r, input logic s,
                              input word_t wd, input flags_t f, input logic e,
                              input logic [PAGE_W-1:0] pc, input logic hold);
      @(posedge clk);
      wir       <= w;
      ragl      <= r;
      skip_test <= s;
      ibus_in   <= wd;
      flags     <= f;
      skip_ext  <= e;
      pc_hi     <= pc;
      rsthold   <= hold;
   endtask

   task automatic idle_cycles(input int n);
      for (int k = 0; k < n; k++) begin
         apply_cycle(1'b0, 1'b0, 1'b0, '0, '0, 1'b0, '0, 1'b0);
      end
   endtask

   task automatic finish_test(input string name);
      $display("%s: %0d checks, %0d errors", name, check_count - chk_base,
               err_count - err_base);
      err_base = err_count;
      chk_base = check_count;
      tests_done++;
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   initial begin
      seed      = 3;
      ibus_in   = '0;
      wir       = 1'b0;
      ragl      = 1'b0;
      skip_test = 1'b0;
      flags     = '0;
      skip_ext  = 1'b0;
      pc_hi     = '0;
      rsthold   = 1'b0;
      wait (rst_n === 1'b1);

      // Bus idle and IR clear out of reset
      idle_cycles(2);
      @(negedge clk);
      if (cbus.ibus_en !== 1'b0) report_mismatch("cbus.ibus_en", 1'b0, cbus.ibus_en);
      if (cbus.skip !== 1'b0) report_mismatch("cbus.skip", 1'b0, cbus.skip);
      if ({cbus.ir12_15, cbus.ir11, cbus.ir2, cbus.ir0} !== 7'h00)
         report_mismatch("cbus.ir_bits", 7'h00, {cbus.ir12_15, cbus.ir11, cbus.ir2, cbus.ir0});
      idle_cycles(1);
      finish_test("reset_state");

      for (int i = 0; i < N_IR; i++) begin
         rnd = $random(seed);
         apply_cycle(1'b1, 1'b0, 1'b0, rnd[15:0], '0, 1'b0, '0, 1'b0);
      end
      idle_cycles(2);
      finish_test("ir_load");

      for (int i = 0; i < N_SKIP; i++) begin
         rnd  = $random(seed);
         word = rnd[15:0];
         ext  = (rnd[23:20] == 4'h0);          // Rare, keeps the flag test visible
         if (i % 10 == 0) begin
            word[4:0] = 5'b1_0000;             // Skip always
            ext       = 1'b0;
         end else if (i % 10 == 5) begin
            word[4:0] = 5'b0_0000;             // Never skip
            ext       = 1'b0;
         end
         apply_cycle(1'b1, 1'b0, 1'b0, word, '0, 1'b0, '0, 1'b0);
         apply_cycle(1'b0, 1'b0, 1'b1, word, rnd[19:16], ext, '0, 1'b0);
      end
      idle_cycles(2);
      finish_test("skip");

      for (int i = 0; i < N_ADDR; i++) begin
         rnd      = $random(seed);
         word     = rnd[15:0];
         word[10] = i[0];                      // Alternate page zero and current page
         apply_cycle(1'b1, 1'b0, 1'b0, word, '0, 1'b0, rnd[21:16], 1'b0);
         apply_cycle(1'b0, 1'b1, 1'b0, word, '0, 1'b0, rnd[21:16], 1'b0);
         if (i % 4 == 0) begin
            rnd = $random(seed);               // Back-to-back ragl, new page
            apply_cycle(1'b0, 1'b1, 1'b0, word, '0, 1'b0, rnd[5:0], 1'b0);
         end
      end
      idle_cycles(2);
      finish_test("address");

      rnd      = $random(seed);
      word     = rnd[15:0];
      word[10] = 1'b1;
      apply_cycle(1'b1, 1'b0, 1'b0, word, '0, 1'b0, rnd[21:16], 1'b0);
      apply_cycle(1'b0, 1'b1, 1'b0, word, '0, 1'b0, rnd[21:16], 1'b1); // ragl under hold
      apply_cycle(1'b0, 1'b0, 1'b0, word, '0, 1'b0, rnd[21:16], 1'b1); // AGL valid now
      @(negedge clk);
      if (cbus.ibus_en !== 1'b1) report_mismatch("cbus.ibus_en", 1'b1, cbus.ibus_en);
      if (cbus.ibus !== RESET_VECTOR) report_mismatch("cbus.ibus", RESET_VECTOR, cbus.ibus);
      apply_cycle(1'b0, 1'b0, 1'b0, word, '0, 1'b0, rnd[21:16], 1'b0);
      @(negedge clk);
      if (cbus.ibus_en !== 1'b0) report_mismatch("cbus.ibus_en", 1'b0, cbus.ibus_en);
      if (cbus.ibus !== 16'h0000) report_mismatch("cbus.ibus", 16'h0000, cbus.ibus);
      idle_cycles(2);
      finish_test("reset_hold");

      err_count += dut_i.sva_i.fail_count;     // Plus bound assertion failures
      $display("Summary: %0d tests, %0d checks, %0d errors", tests_done, check_count,
               err_count);
      if (err_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // Run limit from the strobe count
   initial begin
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
   end

endmodule

//--- verilog.f
cft_pkg.sv
ir_decode.sv
skip_branch_logic.sv
addr_gen.sv
bus_merge.sv
cft_pb1.sv
tb_clock_gen.sv
cft_pb1_sva.sv
cft_pb1_tb.sv

//--- Bender.yml
package:
  name: cft_pb1

sources:
  - files:
      - cft_pkg.sv
      - ir_decode.sv
      - skip_branch_logic.sv
      - addr_gen.sv
      - bus_merge.sv
      - cft_pb1.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - cft_pb1_sva.sv
      - cft_pb1_tb.sv
